/* Makefile */
# Verilator build and run for the IQ sample processor testbench

VERILATOR ?= verilator
TOP       := tb_iq_proc
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_iq_proc.sv */
// Random-stimulus testbench for the IQ processor with a reference model and APB checks
// Inputs change on falling edges; handshakes and outputs are sampled on rising edges
// The gain is rewritten only while no beat is in flight
`timescale 1ns/100ps
`default_nettype none

module tb_iq_proc;

  import iq_proc_pkg::*;

  localparam logic [31:0] SEED = 32'h093a2ad8;
  localparam int N_BASIC = 2000;
  localparam int N_GAINS = 6;
  localparam int N_SCALE = 200;
  localparam int N_FILL  = 60;
  localparam int N_AFTER = 30;
  // The fill test puts six beats in flight ahead of its own burst
  localparam int TOTAL_BEATS = N_BASIC + N_GAINS * N_SCALE + 6 + N_FILL + N_AFTER;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 2000;

  logic              clk = 1'b0;
  logic              i_reset;
  iq_in_t            i_in;
  logic              i_in_valid;
  logic              o_in_ready;
  iq_sample_t        o_out;
  logic              o_out_valid;
  logic              i_out_ready;
  logic              i_psel;
  logic              i_penable;
  logic              i_pwrite;
  logic [APB_AW-1:0] i_paddr;
  logic [31:0]       i_pwdata;
  logic [31:0]       o_prdata;
  logic              o_pready;
  logic              o_pslverr;

  logic [31:0] lcg_state = SEED;
  logic [15:0] cur_gain = GAIN_RESET;
  iq_sample_t  exp_q[$];
  int          cycle_count = 0;
  int          exp_samples = 0;
  int          exp_sats = 0;
  // Set on every rising edge, read by the stimulus on the next falling edge
  bit          in_fire = 1'b0;

  always #10 clk = ~clk;

  iq_proc_top dut0 (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Roughly seven times in ten, from the upper LCG bits
  function automatic bit chance70();
    logic [31:0] r;
    r = lcg_next();
    return (r[31:16] % 16'd100) < 16'd70;
  endfunction

  function automatic iq_in_t random_beat(input int op_count);
    iq_in_t      b;
    logic [31:0] r;
    int          op_idx;
    r = lcg_next();
    b.sample.i = r[31:16];
    r = lcg_next();
    b.sample.q = r[31:16];
    r = lcg_next();
    // Hit the rails often so the -32768 and saturation cases show up
    if (r[31:29] == 3'd0) b.sample.q = 16'h8000;
    if (r[28:26] == 3'd0) b.sample.i = 16'h8000;
    if (r[25:23] == 3'd0) b.sample.i = 16'h7fff;
    b.sample.last = (r[22:20] == 3'd0);
    op_idx = int'(r[19:12]) % op_count;
    b.op = iq_op_e'(op_idx[1:0]);
    return b;
  endfunction

  function automatic int clamp16(input int v, inout bit hit);
    if (v > 32767) begin
      hit = 1'b1;
      return 32767;
    end
    if (v < -32768) begin
      hit = 1'b1;
      return -32768;
    end
    return v;
  endfunction

  // Reference arithmetic: exact integer result, then one saturation to 16 bits
  function automatic iq_sample_t model_sample(input iq_in_t beat, input logic [15:0] gain,
                                              output bit clipped);
    int         vi;
    int         vq;
    int         tmp;
    iq_sample_t s;
    vi = int'($signed(beat.sample.i));
    vq = int'($signed(beat.sample.q));
    clipped = 1'b0;
    case (beat.op)
      OP_CONJ: vq = -vq;
      OP_SWAP: begin
        tmp = vi;
        vi  = vq;
        vq  = tmp;
      end
      OP_SCALE: begin
        // Q1.14 gain, half an LSB added before the arithmetic shift
        vi = (vi * int'($signed(gain)) + 8192) >>> 14;
        vq = (vq * int'($signed(gain)) + 8192) >>> 14;
      end
      default: ;
    endcase
    s.i    = 16'(clamp16(vi, clipped));
    s.q    = 16'(clamp16(vq, clipped));
    s.last = beat.sample.last;
    return s;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_sample(input iq_sample_t expected, input iq_sample_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf(
        "error: t=%0t o_out expected i=%h q=%h last=%b got i=%h q=%h last=%b", $time,
        expected.i, expected.q, expected.last, actual.i, actual.q, actual.last));
    end
  endtask

  task automatic compare_reg(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error: t=%0t %s expected %h got %h",
                                  $time, name, expected, actual));
    end
  endtask

  // Setup phase on one falling edge, access phase on the next, result at the rising edge
  task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, input logic expect_err,
                            output logic [31:0] rdata);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = write;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;
    @(posedge clk);
    rdata = o_prdata;
    if (o_pready !== 1'b1) begin
      stop_with_failure("PREADY was low in an APB access phase");
    end
    if (o_pslverr !== expect_err) begin
      stop_with_failure($sformatf("error: t=%0t o_pslverr expected %b got %b at 0x%h",
                                  $time, expect_err, o_pslverr, addr));
    end
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                           input logic expect_err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, expect_err, unused);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, 1'b0, data);
  endtask

  task automatic check_counters();
    logic [31:0] rd;
    apb_read(REG_SAMPLES, rd);
    compare_reg("REG_SAMPLES", 32'(exp_samples), rd);
    apb_read(REG_SATS, rd);
    compare_reg("REG_SATS", 32'(exp_sats), rd);
  endtask

  // Offer a number of beats with random gaps and random output stalls
  task automatic run_burst(input int beats, input int op_count);
    int sent;
    sent = 0;
    while (sent < beats) begin
      @(negedge clk);
      if (in_fire) sent = sent + 1;
      if (!i_in_valid || in_fire) begin
        i_in_valid = (sent < beats) && chance70();
        if (i_in_valid) i_in = random_beat(op_count);
      end
      i_out_ready = chance70();
    end
  endtask

  task automatic drain_pipeline();
    while (exp_q.size() != 0) begin
      @(negedge clk);
      i_out_ready = chance70();
    end
    if (o_out_valid !== 1'b0) begin
      stop_with_failure("output still valid after every expected beat was delivered");
    end
    i_out_ready = 1'b1;
  endtask

  // Scoreboard: push on input transfers, pop and compare on output transfers
  always @(posedge clk) begin : monitor
    iq_sample_t expected;
    bit         clipped;
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      stop_with_failure($sformatf("timeout after %0d cycles with %0d beats outstanding",
                                  cycle_count, exp_q.size()));
    end
    in_fire = i_in_valid && o_in_ready;
    if (in_fire) begin
      expected = model_sample(i_in, cur_gain, clipped);
      exp_q.push_back(expected);
      if (clipped) exp_sats = exp_sats + 1;
    end
    if (o_out_valid && i_out_ready) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("output transfer with no matching input beat");
      end else begin
        expected = exp_q.pop_front();
        compare_sample(expected, o_out);
        exp_samples = exp_samples + 1;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [15:0] gain_list [N_GAINS];
    i_reset     = 1'b1;
    i_in        = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    i_reset     = 1'b0;
    i_out_ready = 1'b1;

    // Reset state: unity gain, zero counters, counters refuse writes
    @(negedge clk);
    if (o_out_valid !== 1'b0 || o_in_ready !== 1'b1) begin
      stop_with_failure("stream handshake not idle after reset");
    end
    apb_read(REG_GAIN, rd);
    compare_reg("REG_GAIN", 32'h0000_4000, rd);
    check_counters();
    apb_write(REG_SAMPLES, 32'h0000_1234, 1'b1);
    check_counters();

    // Pass, conjugate and swap under random back-pressure
    run_burst(N_BASIC, 3);
    drain_pipeline();
    check_counters();

    // Scaling over a spread of gains, each written with the pipeline empty
    rnd = lcg_next();
    gain_list[0] = 16'h7fff;
    gain_list[1] = 16'h8000;
    gain_list[2] = rnd[31:16];
    gain_list[3] = {1'b1, rnd[30:16]};
    gain_list[4] = {6'b011111, rnd[25:16]};
    gain_list[5] = 16'hc000;
    for (int g = 0; g < N_GAINS; g++) begin
      apb_write(REG_GAIN, {16'd0, gain_list[g]}, 1'b0);
      cur_gain = gain_list[g];
      apb_read(REG_GAIN, rd);
      compare_reg("REG_GAIN", {16'd0, gain_list[g]}, rd);
      run_burst(N_SCALE, 4);
      drain_pipeline();
      check_counters();
    end

    // Stall the output until all three buffers are full
    i_out_ready = 1'b0;
    do begin
      @(negedge clk);
      if (!i_in_valid || in_fire) begin
        i_in       = random_beat(4);
        i_in_valid = 1'b1;
      end
    end while (o_in_ready);
    repeat (8) begin
      @(negedge clk);
      if (o_in_ready !== 1'b0) begin
        stop_with_failure($sformatf("error: t=%0t o_in_ready expected 0 got %b",
                                    $time, o_in_ready));
      end
      if (exp_q.size() != 6) begin
        stop_with_failure($sformatf("error: t=%0t beats in flight expected 6 got %0d",
                                    $time, exp_q.size()));
      end
    end
    run_burst(N_FILL, 4);
    drain_pipeline();
    check_counters();

    // Soft clear while idle empties both counters
    apb_write(REG_CTRL, 32'h0000_0001, 1'b0);
    exp_samples = 0;
    exp_sats    = 0;
    check_counters();
    apb_read(REG_CTRL, rd);
    compare_reg("REG_CTRL", 32'd0, rd);
    repeat (10) begin
      @(negedge clk);
      if (o_out_valid !== 1'b0) begin
        stop_with_failure("output went valid after a clear with no new input");
      end
    end
    run_burst(N_AFTER, 4);
    drain_pipeline();
    check_counters();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/iq_proc_pkg.sv
verilog/stream_flop2.sv
verilog/iq_decode.sv
verilog/iq_execute.sv
verilog/iq_result.sv
verilog/iq_apb_regs.sv
verilog/iq_proc_top.sv
tb/tb_iq_proc.sv

/* verilog/iq_apb_regs.sv */
// APB slave with zero wait states, PREADY tied high
// Gain reads back zero-extended; counters are read-only and wrap at 2^32
// A control write of bit 0 clears the stream buffers and both counters
`timescale 1ns/100ps
`default_nettype none

module iq_apb_regs (
  input  wire                              clk,
  input  wire                              i_reset,
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_pwrite,
  input  wire [iq_proc_pkg::APB_AW-1:0]    i_paddr,
  input  wire [31:0]                       i_pwdata,
  output logic [31:0]                      o_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  input  wire                              i_sample_done,
  input  wire                              i_sat,
  output logic [iq_proc_pkg::SAMPLE_W-1:0] o_gain,
  output logic                             o_clear
);

  import iq_proc_pkg::*;

  logic        access;
  logic        wr;
  logic        mapped;
  logic        read_only;
  logic [31:0] samples_cnt;
  logic [31:0] sats_cnt;

  // Transfers complete in the access phase
  assign access    = i_psel && i_penable;
  assign wr        = access && i_pwrite;
  assign mapped    = (i_paddr == REG_GAIN) || (i_paddr == REG_CTRL) ||
                     (i_paddr == REG_SAMPLES) || (i_paddr == REG_SATS);
  assign read_only = (i_paddr == REG_SAMPLES) || (i_paddr == REG_SATS);

  assign o_pready  = 1'b1;
  assign o_pslverr = access && (!mapped || (i_pwrite && read_only));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_gain  <= GAIN_RESET;
      o_clear <= 1'b0;
    end else begin
      if (wr && (i_paddr == REG_GAIN)) begin
        o_gain <= i_pwdata[SAMPLE_W-1:0];
      end
      // Single-cycle pulse, the control register itself holds nothing
      o_clear <= wr && (i_paddr == REG_CTRL) && i_pwdata[0];
    end
  end

  // Counters count delivered samples, writes from the bus are ignored
  always_ff @(posedge clk) begin
    if (i_reset || o_clear) begin
      samples_cnt <= '0;
      sats_cnt    <= '0;
    end else begin
      if (i_sample_done) begin
        samples_cnt <= samples_cnt + 32'd1;
      end
      if (i_sat) begin
        sats_cnt <= sats_cnt + 32'd1;
      end
    end
  end

  always_comb begin
    unique case (i_paddr)
      REG_GAIN:    o_prdata = {{(32-SAMPLE_W){1'b0}}, o_gain};
      REG_SAMPLES: o_prdata = samples_cnt;
      REG_SATS:    o_prdata = sats_cnt;
      default:     o_prdata = 32'd0;
    endcase
  end

  // The master must select the slave before entering the access phase
  a_penable_psel : assert property (@(posedge clk) disable iff (i_reset)
    $rose(i_penable) |-> i_psel);

endmodule

`default_nettype wire

/* verilog/iq_decode.sv */
// Decode stage: operation code to one-hot control flags
// One cycle of latency through its output buffer
`timescale 1ns/100ps
`default_nettype none

module iq_decode (
  input  wire                    clk,
  input  wire                    i_reset,
  input  wire                    i_clear,
  input  iq_proc_pkg::iq_in_t    i_in,
  input  wire                    i_in_valid,
  output logic                   o_in_ready,
  output iq_proc_pkg::iq_ctrl_t  o_ctrl,
  output logic                   o_ctrl_valid,
  input  wire                    i_ctrl_ready
);

  import iq_proc_pkg::*;

  iq_ctrl_t ctrl;

  // Each code sets at most one flag, pass sets none
  always_comb begin
    ctrl.sample   = i_in.sample;
    ctrl.swap     = 1'b0;
    ctrl.negate_q = 1'b0;
    ctrl.scale    = 1'b0;
    unique case (i_in.op)
      OP_CONJ:  ctrl.negate_q = 1'b1;
      OP_SWAP:  ctrl.swap     = 1'b1;
      OP_SCALE: ctrl.scale    = 1'b1;
      default:  ;
    endcase
  end

  stream_flop2 #(.T(iq_ctrl_t)) u_buf (
    .clk     (clk),
    .i_reset (i_reset),
    .i_clear (i_clear),
    .i_data  (ctrl),
    .i_valid (i_in_valid),
    .o_ready (o_in_ready),
    .o_data  (o_ctrl),
    .o_valid (o_ctrl_valid),
    .i_ready (i_ctrl_ready)
  );

endmodule

`default_nettype wire

/* verilog/iq_execute.sv */
// Execute stage: swap, Q negation or gain multiply into 18-bit values
// The gain is sampled as a beat enters the buffer, so change it only when idle
// Scaling rounds half up before the shift and clips to the 18-bit range
`timescale 1ns/100ps
`default_nettype none

module iq_execute (
  input  wire                    clk,
  input  wire                    i_reset,
  input  wire                    i_clear,
  input  wire [15:0]             i_gain,
  input  iq_proc_pkg::iq_ctrl_t  i_ctrl,
  input  wire                    i_ctrl_valid,
  output logic                   o_ctrl_ready,
  output iq_proc_pkg::iq_wide_t  o_wide,
  output logic                   o_wide_valid,
  input  wire                    i_wide_ready
);

  import iq_proc_pkg::*;

  logic signed [WIDE_W-1:0] ext_i;
  logic signed [WIDE_W-1:0] ext_q;
  logic signed [31:0]       prod_i;
  logic signed [31:0]       prod_q;
  logic signed [31:0]       rnd_i;
  logic signed [31:0]       rnd_q;
  iq_wide_t                 wide;

  // Limit a rounded product to what the widened path can carry
  function automatic logic [WIDE_W-1:0] clip_wide(input logic signed [31:0] v);
    if (v > WIDE_MAX) begin
      return WIDE_W'(WIDE_MAX);
    end else if (v < WIDE_MIN) begin
      return WIDE_W'(WIDE_MIN);
    end
    return v[WIDE_W-1:0];
  endfunction

  always_comb begin
    // Sign extension leaves room for negating -32768
    ext_i  = $signed(i_ctrl.sample.i);
    ext_q  = $signed(i_ctrl.sample.q);
    // Q1.14 product, then round and drop the fraction
    prod_i = $signed(i_ctrl.sample.i) * $signed(i_gain);
    prod_q = $signed(i_ctrl.sample.q) * $signed(i_gain);
    rnd_i  = (prod_i + ROUND_HALF) >>> GAIN_FRAC;
    rnd_q  = (prod_q + ROUND_HALF) >>> GAIN_FRAC;

    wide.last = i_ctrl.sample.last;
    if (i_ctrl.scale) begin
      wide.i = clip_wide(rnd_i);
      wide.q = clip_wide(rnd_q);
    end else if (i_ctrl.swap) begin
      wide.i = ext_q;
      wide.q = ext_i;
    end else if (i_ctrl.negate_q) begin
      wide.i = ext_i;
      wide.q = -ext_q;
    end else begin
      wide.i = ext_i;
      wide.q = ext_q;
    end
  end

  stream_flop2 #(.T(iq_wide_t)) u_buf (
    .clk     (clk),
    .i_reset (i_reset),
    .i_clear (i_clear),
    .i_data  (wide),
    .i_valid (i_ctrl_valid),
    .o_ready (o_ctrl_ready),
    .o_data  (o_wide),
    .o_valid (o_wide_valid),
    .i_ready (i_wide_ready)
  );

  // Decode must never hand over more than one operation per beat
  a_one_op : assert property (@(posedge clk) disable iff (i_reset)
    i_ctrl_valid |-> $onehot0({i_ctrl.swap, i_ctrl.negate_q, i_ctrl.scale}));

endmodule

`default_nettype wire

/* verilog/iq_proc_pkg.sv */
// Shared types and constants for the IQ sample processor
// Components are signed 16-bit two's complement; the gain is signed Q1.14
// Execute-stage values are widened to WIDE_W bits before the final saturation
`default_nettype none

package iq_proc_pkg;

  // Component and arithmetic widths
  localparam int SAMPLE_W  = 16;
  localparam int GAIN_FRAC = 14;
  localparam int WIDE_W    = 18;

  // Saturation bounds for the output sample and for the widened execute values
  localparam int SAMPLE_MAX = (1 << (SAMPLE_W - 1)) - 1;
  localparam int SAMPLE_MIN = -(1 << (SAMPLE_W - 1));
  localparam int WIDE_MAX   = (1 << (WIDE_W - 1)) - 1;
  localparam int WIDE_MIN   = -(1 << (WIDE_W - 1));

  // Half an LSB of the Q1.14 product, added before the arithmetic shift
  localparam int ROUND_HALF = 1 << (GAIN_FRAC - 1);

  // APB register map
  localparam int APB_AW = 8;
  localparam logic [APB_AW-1:0] REG_GAIN    = 8'h00;
  localparam logic [APB_AW-1:0] REG_CTRL    = 8'h04;
  localparam logic [APB_AW-1:0] REG_SAMPLES = 8'h08;
  localparam logic [APB_AW-1:0] REG_SATS    = 8'h0C;

  // Unity gain in Q1.14
  localparam logic [SAMPLE_W-1:0] GAIN_RESET = 16'h4000;

  typedef enum logic [1:0] {
    OP_PASS  = 2'd0,
    OP_CONJ  = 2'd1,
    OP_SWAP  = 2'd2,
    OP_SCALE = 2'd3
  } iq_op_e;

  // Stream payload at the top-level input and output
  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
    logic                last;
  } iq_sample_t;

  // Input beat: sample plus its operation sideband
  typedef struct packed {
    iq_sample_t sample;
    iq_op_e     op;
  } iq_in_t;

  // Decoded control, at most one flag set
  typedef struct packed {
    iq_sample_t sample;
    logic       swap;
    logic       negate_q;
    logic       scale;
  } iq_ctrl_t;

  // Execute-stage result before saturation
  typedef struct packed {
    logic [WIDE_W-1:0] i;
    logic [WIDE_W-1:0] q;
    logic              last;
  } iq_wide_t;

endpackage

`default_nettype wire

/* verilog/iq_proc_top.sv */
// IQ sample processor top level: decode, execute and result stages plus APB registers
// Three cycles from input transfer to output valid with no back-pressure
// Up to six beats in flight; a soft clear drops them all
`timescale 1ns/100ps
`default_nettype none

module iq_proc_top (
  input  wire                           clk,
  input  wire                           i_reset,
  input  iq_proc_pkg::iq_in_t           i_in,
  input  wire                           i_in_valid,
  output logic                          o_in_ready,
  output iq_proc_pkg::iq_sample_t       o_out,
  output logic                          o_out_valid,
  input  wire                           i_out_ready,
  input  wire                           i_psel,
  input  wire                           i_penable,
  input  wire                           i_pwrite,
  input  wire [iq_proc_pkg::APB_AW-1:0] i_paddr,
  input  wire [31:0]                    i_pwdata,
  output logic [31:0]                   o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr
);

  import iq_proc_pkg::*;

  // Stage-to-stage streams
  iq_ctrl_t            ctrl;
  logic                ctrl_valid;
  logic                ctrl_ready;
  iq_wide_t            wide;
  logic                wide_valid;
  logic                wide_ready;
  // Register block side signals
  logic [SAMPLE_W-1:0] gain;
  logic                clear;
  logic                sample_done;
  logic                sat;

  iq_decode u_decode (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_clear      (clear),
    .i_in         (i_in),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .o_ctrl       (ctrl),
    .o_ctrl_valid (ctrl_valid),
    .i_ctrl_ready (ctrl_ready)
  );

  iq_execute u_execute (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_clear      (clear),
    .i_gain       (gain),
    .i_ctrl       (ctrl),
    .i_ctrl_valid (ctrl_valid),
    .o_ctrl_ready (ctrl_ready),
    .o_wide       (wide),
    .o_wide_valid (wide_valid),
    .i_wide_ready (wide_ready)
  );

  iq_result u_result (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_clear       (clear),
    .i_wide        (wide),
    .i_wide_valid  (wide_valid),
    .o_wide_ready  (wide_ready),
    .o_out         (o_out),
    .o_out_valid   (o_out_valid),
    .i_out_ready   (i_out_ready),
    .o_sample_done (sample_done),
    .o_sat         (sat)
  );

  iq_apb_regs u_regs (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .i_sample_done (sample_done),
    .i_sat         (sat),
    .o_gain        (gain),
    .o_clear       (clear)
  );

endmodule

`default_nettype wire

/* verilog/iq_result.sv */
// Result stage: saturate 18-bit values back to 16-bit components
// Done and saturation events fire on output transfer, not on entry
`timescale 1ns/100ps
`default_nettype none

module iq_result (
  input  wire                      clk,
  input  wire                      i_reset,
  input  wire                      i_clear,
  input  iq_proc_pkg::iq_wide_t    i_wide,
  input  wire                      i_wide_valid,
  output logic                     o_wide_ready,
  output iq_proc_pkg::iq_sample_t  o_out,
  output logic                     o_out_valid,
  input  wire                      i_out_ready,
  output logic                     o_sample_done,
  output logic                     o_sat
);

  import iq_proc_pkg::*;

  iq_sample_t sample;
  logic       sat_i;
  logic       sat_q;
  logic       sat_held;

  // Clamp each component and note whether either one hit a rail
  always_comb begin
    sat_i = 1'b1;
    sat_q = 1'b1;
    if ($signed(i_wide.i) > SAMPLE_MAX) begin
      sample.i = SAMPLE_W'(SAMPLE_MAX);
    end else if ($signed(i_wide.i) < SAMPLE_MIN) begin
      sample.i = SAMPLE_W'(SAMPLE_MIN);
    end else begin
      sample.i = i_wide.i[SAMPLE_W-1:0];
      sat_i    = 1'b0;
    end
    if ($signed(i_wide.q) > SAMPLE_MAX) begin
      sample.q = SAMPLE_W'(SAMPLE_MAX);
    end else if ($signed(i_wide.q) < SAMPLE_MIN) begin
      sample.q = SAMPLE_W'(SAMPLE_MIN);
    end else begin
      sample.q = i_wide.q[SAMPLE_W-1:0];
      sat_q    = 1'b0;
    end
    sample.last = i_wide.last;
  end

  stream_flop2 #(.T(iq_sample_t)) u_buf (
    .clk     (clk),
    .i_reset (i_reset),
    .i_clear (i_clear),
    .i_data  (sample),
    .i_valid (i_wide_valid),
    .o_ready (o_wide_ready),
    .o_data  (o_out),
    .o_valid (o_out_valid),
    .i_ready (i_out_ready)
  );

  // Saturation flag rides in a parallel buffer with the same handshake
  stream_flop2 #(.T(logic)) u_sat_buf (
    .clk     (clk),
    .i_reset (i_reset),
    .i_clear (i_clear),
    .i_data  (sat_i || sat_q),
    .i_valid (i_wide_valid),
    .o_ready (),
    .o_data  (sat_held),
    .o_valid (),
    .i_ready (i_out_ready)
  );

  assign o_sample_done = o_out_valid && i_out_ready;
  assign o_sat         = o_sample_done && sat_held;

endmodule

`default_nettype wire

/* verilog/stream_flop2.sv */
// Two-entry registered stream buffer with one cycle of latency
// Input ready never depends combinationally on output ready
// The source must hold valid and data until the transfer; reset and clear drop only valids
`timescale 1ns/100ps
`default_nettype none

module stream_flop2 #(
  parameter type T = logic [31:0]
) (
  input  wire  clk,
  input  wire  i_reset,
  input  wire  i_clear,
  input  T     i_data,
  input  wire  i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  wire  i_ready
);

  // Main register takes every input beat, skid register catches it on a stall
  T     data_main;
  T     data_skid;
  logic valid_main;
  logic valid_skid;

  always_ff @(posedge clk) begin
    // Load the main register whenever there is room
    if (o_ready) begin
      data_main  <= i_data;
      valid_main <= i_valid;
    end
    if (i_ready) begin
      if (o_ready) begin
        data_skid <= data_main;
        // Skid drains back to the direct path once the main entry is empty
        if (valid_skid) begin
          valid_skid <= valid_main;
        end
      end else begin
        // Both full and skid consumed, so the main entry moves up
        data_skid  <= data_main;
        valid_skid <= valid_main;
        valid_main <= 1'b0;
      end
    end else if (!valid_skid) begin
      // Output stalled, park the main entry in the skid register
      data_skid  <= data_main;
      valid_skid <= valid_main;
    end
    if (i_reset || i_clear) begin
      valid_main <= 1'b0;
      valid_skid <= 1'b0;
    end
  end

  // Ready is a function of the stored valid bits only
  assign o_ready = !i_reset && !(valid_main && valid_skid);

  // The skid entry is always the older one when both are held
  assign o_valid = valid_skid || valid_main;
  assign o_data  = valid_skid ? data_skid : data_main;

  // Back-pressure only ever follows a beat held against a stalled output
  a_ready_full : assert property (@(posedge clk) disable iff (i_reset)
    !o_ready |-> $past(o_valid && !i_ready));

  // A beat offered downstream stays put until it is taken
  a_out_stable : assert property (@(posedge clk) disable iff (i_reset || i_clear)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

`default_nettype wire
